// File: mem_pkg.sv
package mem_pkg;

    // one access on any request link (cpu, cache refill/write-back, bypass, memory)
    typedef struct packed {
        logic        strobe;  // level, held until ready
        logic        rw;      // 1 = write
        logic [3:0]  wen;     // byte lanes, lane 3 is bits 31:24
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // response, ready is a single-cycle pulse
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_rsp_t;

    // kseg0, cached view of physical segments 0 and 1
    localparam logic [3:0] SEG_KSEG0_LO = 4'h8;
    localparam logic [3:0] SEG_KSEG0_HI = 4'h9;

    // kseg1, uncached view of the same physical space
    localparam logic [3:0] SEG_KSEG1_LO = 4'hA;
    localparam logic [3:0] SEG_KSEG1_HI = 4'hB;

    // access size codes
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;  // used for line transfers

endpackage

// File: addr_map.sv
`timescale 1ns/1ps

module addr_map (
    input  mem_pkg::bus_req_t cpu_req,
    output mem_pkg::bus_req_t cache_req,
    output mem_pkg::bus_req_t byp_req
);

    logic [3:0]  seg;
    logic        is_kseg0;
    logic        is_kseg1;
    logic [31:0] phys_addr;

    assign seg = cpu_req.addr[31:28];

    assign is_kseg0 = (seg == mem_pkg::SEG_KSEG0_LO) || (seg == mem_pkg::SEG_KSEG0_HI);
    assign is_kseg1 = (seg == mem_pkg::SEG_KSEG1_LO) || (seg == mem_pkg::SEG_KSEG1_HI);

    // kseg0/kseg1 fold onto physical segments 0 and 1
    always_comb begin
        if (is_kseg0 || is_kseg1) begin
            phys_addr = {3'b000, cpu_req.addr[28:0]};
        end else begin
            phys_addr = cpu_req.addr;  // everything else untranslated
        end
    end

    // cached side gets all but kseg1
    always_comb begin
        cache_req        = cpu_req;
        cache_req.addr   = phys_addr;
        cache_req.strobe = cpu_req.strobe && !is_kseg1;
    end

    // uncached bypass
    always_comb begin
        byp_req        = cpu_req;
        byp_req.addr   = phys_addr;
        byp_req.strobe = cpu_req.strobe && is_kseg1;
    end

endmodule

// File: d_cache.sv
`timescale 1ns/1ps

module d_cache #(
    parameter int C_INDEX = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::bus_req_t cpu_req,
    output mem_pkg::bus_rsp_t cpu_rsp,
    output mem_pkg::bus_req_t mem_req,
    input  mem_pkg::bus_rsp_t mem_rsp
);

    localparam int LINES   = 1 << C_INDEX;
    localparam int T_WIDTH = 30 - C_INDEX;  // one word per line

    // controller states
    localparam logic [1:0] S_SERVE  = 2'd0;
    localparam logic [1:0] S_WBACK  = 2'd1;
    localparam logic [1:0] S_REFILL = 2'd2;

    logic [1:0] state;

    // line storage
    logic [LINES-1:0]   line_valid;
    logic [LINES-1:0]   line_dirty;
    logic [T_WIDTH-1:0] line_tag  [LINES];
    logic [3:0][7:0]    line_data [LINES];

    // lookup
    logic [C_INDEX-1:0] index;
    logic [T_WIDTH-1:0] tag;
    logic [T_WIDTH-1:0] tag_out;
    logic [31:0]        data_out;
    logic               cur_valid;
    logic               cur_dirty;
    logic               in_serve;
    logic               hit;
    logic               miss;
    logic               wr_hit;
    logic               wb_done;
    logic               refill_done;

    assign index = cpu_req.addr[C_INDEX+1:2];
    assign tag   = cpu_req.addr[31:C_INDEX+2];

    assign tag_out   = line_tag[index];
    assign data_out  = line_data[index];
    assign cur_valid = line_valid[index];
    assign cur_dirty = line_dirty[index];

    assign in_serve = (state == S_SERVE);

    // hit/miss only decided while serving the cpu
    assign hit    = in_serve && cpu_req.strobe && cur_valid && (tag_out == tag);
    assign miss   = in_serve && cpu_req.strobe && !(cur_valid && (tag_out == tag));
    assign wr_hit = hit && cpu_req.rw;

    assign wb_done     = (state == S_WBACK) && mem_rsp.ready;
    assign refill_done = (state == S_REFILL) && mem_rsp.ready;

    // cpu side, a hit answers in the strobe cycle
    assign cpu_rsp.ready = hit;
    assign cpu_rsp.rdata = data_out;

    // valid/dirty bits
    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (refill_done) begin
            line_valid[index] <= 1'b1;  // refilled line is clean
            line_dirty[index] <= 1'b0;
        end else if (wr_hit) begin
            line_dirty[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (refill_done) begin
            line_tag[index]  <= tag;
            line_data[index] <= mem_rsp.rdata;
        end else if (wr_hit) begin
            // only enabled lanes change
            for (int b = 0; b < 4; b++) begin
                if (cpu_req.wen[b]) begin
                    line_data[index][b] <= cpu_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // controller
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_SERVE;
        end else begin
            case (state)
                S_SERVE: begin
                    if (miss) begin
                        if (cur_valid && cur_dirty) begin
                            state <= S_WBACK;  // old line must go out first
                        end else begin
                            state <= S_REFILL;
                        end
                    end
                end
                S_WBACK: begin
                    if (wb_done) begin
                        state <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (refill_done) begin
                        state <= S_SERVE;  // retried access hits next cycle
                    end
                end
                default: begin
                    state <= S_SERVE;
                end
            endcase
        end
    end

    // memory side request
    always_comb begin
        mem_req      = '0;
        mem_req.size = mem_pkg::SIZE_WORD;
        case (state)
            S_WBACK: begin
                mem_req.strobe = 1'b1;
                mem_req.rw     = 1'b1;
                mem_req.wen    = 4'b1111;
                mem_req.addr   = {tag_out, index, 2'b00};  // rebuilt from old tag
                mem_req.wdata  = data_out;
            end
            S_REFILL: begin
                mem_req.strobe = 1'b1;
                mem_req.rw     = 1'b0;
                mem_req.wen    = 4'b0000;
                mem_req.addr   = {tag, index, 2'b00};
            end
            default: begin
                mem_req.strobe = 1'b0;  // idle while serving
            end
        endcase
    end

endmodule

// File: mem_port_mux.sv
`timescale 1ns/1ps

module mem_port_mux (
    input  mem_pkg::bus_req_t byp_req,
    input  mem_pkg::bus_req_t cache_mem_req,
    input  mem_pkg::bus_rsp_t cache_rsp,
    output mem_pkg::bus_rsp_t cache_mem_rsp,
    output mem_pkg::bus_req_t mem_req,
    input  mem_pkg::bus_rsp_t mem_rsp,
    output mem_pkg::bus_rsp_t cpu_rsp
);

    logic byp_sel;

    // bypass owns the bus only while its strobe is up
    assign byp_sel = byp_req.strobe;

    always_comb begin
        if (byp_sel) begin
            mem_req = byp_req;
        end else begin
            mem_req = cache_mem_req;
        end
    end

    // memory response back to the cache, ready masked when bypass has the bus
    always_comb begin
        cache_mem_rsp.rdata = mem_rsp.rdata;
        cache_mem_rsp.ready = mem_rsp.ready && !byp_sel;
    end

    // cpu sees the memory directly for uncached accesses
    always_comb begin
        if (byp_sel) begin
            cpu_rsp = mem_rsp;
        end else begin
            cpu_rsp = cache_rsp;
        end
    end

endmodule

// File: main_mem.sv
`timescale 1ns/1ps

module main_mem #(
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::bus_req_t mem_req,
    output mem_pkg::bus_rsp_t mem_rsp
);

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(MEM_LATENCY + 1);

    logic [3:0][7:0] mem [MEM_WORDS];

    logic          busy;       // request in flight
    logic [CW-1:0] cnt;        // cycles since strobe first seen
    logic [AW-1:0] word_addr;
    logic          done;

    // word address wraps modulo the depth
    assign word_addr = mem_req.addr[AW+1:2];

    assign done = busy && mem_req.strobe && (cnt == CW'(MEM_LATENCY));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (done) begin
            busy <= 1'b0;  // rearm for next request
            cnt  <= '0;
        end else if (busy && !mem_req.strobe) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end else if (mem_req.strobe) begin
            busy <= 1'b1;
            cnt  <= CW'(1);
        end
    end

    // writes land in the ready cycle
    always_ff @(posedge clk) begin
        if (done && mem_req.rw) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.wen[b]) begin
                    mem[word_addr][b] <= mem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    assign mem_rsp.ready = done;
    assign mem_rsp.rdata = mem[word_addr];  // valid while ready is high

endmodule

// File: data_mem_top.sv
`timescale 1ns/1ps

module data_mem_top #(
    parameter int C_INDEX     = 6,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::bus_req_t cpu_req,
    output mem_pkg::bus_rsp_t cpu_rsp
);

    mem_pkg::bus_req_t cache_req;
    mem_pkg::bus_req_t byp_req;
    mem_pkg::bus_rsp_t cache_rsp;
    mem_pkg::bus_req_t cache_mem_req;
    mem_pkg::bus_rsp_t cache_mem_rsp;
    mem_pkg::bus_req_t mem_req;
    mem_pkg::bus_rsp_t mem_rsp;

    addr_map addr_map_i (
        .cpu_req   (cpu_req),
        .cache_req (cache_req),
        .byp_req   (byp_req)
    );

    d_cache #(
        .C_INDEX (C_INDEX)
    ) d_cache_i (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cache_req),
        .cpu_rsp (cache_rsp),
        .mem_req (cache_mem_req),
        .mem_rsp (cache_mem_rsp)
    );

    mem_port_mux mem_port_mux_i (
        .byp_req       (byp_req),
        .cache_mem_req (cache_mem_req),
        .cache_rsp     (cache_rsp),
        .cache_mem_rsp (cache_mem_rsp),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp),
        .cpu_rsp       (cpu_rsp)
    );

    main_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) main_mem_i (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// File: tb_data_mem.sv
`timescale 1ns/1ps

module tb_data_mem;

    localparam int C_INDEX     = 6;
    localparam int MEM_WORDS   = 1024;
    localparam int MEM_LATENCY = 3;
    localparam int LINES       = 1 << C_INDEX;
    localparam int MAX_WAIT    = 200;

    logic              clk;
    logic              rst;
    mem_pkg::bus_req_t cpu_req;
    mem_pkg::bus_rsp_t cpu_rsp;

    // reference memory and cache
    logic [31:0] ref_mem   [MEM_WORDS];
    logic        ref_valid [LINES];
    logic        ref_dirty [LINES];
    logic [31:0] ref_tag   [LINES];  // phys >> (C_INDEX+2)
    logic [31:0] ref_data  [LINES];

    logic [31:0] rng;
    logic [3:0]  wen_set [7];
    logic        hung;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_start_errs;

    data_mem_top #(
        .C_INDEX     (C_INDEX),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) dut_i (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  wen);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // kseg0/kseg1 drop the top three bits, the rest passes through
    function automatic logic [31:0] phys_of(input logic [31:0] addr);
        if (addr[31:30] == 2'b10) begin
            return {3'b000, addr[28:0]};
        end
        return addr;
    endfunction

    function automatic logic [1:0] size_of(input logic [3:0] wen);
        int n;
        n = $countones(wen);
        if (n == 1) begin
            return mem_pkg::SIZE_BYTE;
        end else if (n == 2) begin
            return mem_pkg::SIZE_HALF;
        end
        return mem_pkg::SIZE_WORD;
    endfunction

    // one access applied to the reference, exp is the read value
    task automatic model_step(input logic [31:0] addr, input logic rw, input logic [3:0] wen,
                              input logic [31:0] wdata, output logic [31:0] exp);
        logic [31:0] phys;
        logic [31:0] tg;
        int unsigned idx;
        int unsigned word;
        int unsigned old_word;
        phys = phys_of(addr);
        word = (phys >> 2) % MEM_WORDS;
        exp  = '0;
        if (addr[31:28] == mem_pkg::SEG_KSEG1_LO || addr[31:28] == mem_pkg::SEG_KSEG1_HI) begin
            if (rw) begin
                ref_mem[word] = merge_lanes(ref_mem[word], wdata, wen);
            end else begin
                exp = ref_mem[word];
            end
        end else begin
            idx = (phys >> 2) % LINES;
            tg  = phys >> (C_INDEX + 2);
            if (!(ref_valid[idx] && ref_tag[idx] == tg)) begin
                if (ref_valid[idx] && ref_dirty[idx]) begin
                    old_word = ((ref_tag[idx] << C_INDEX) | idx) % MEM_WORDS;
                    ref_mem[old_word] = ref_data[idx];  // write-back
                end
                ref_valid[idx] = 1'b1;
                ref_dirty[idx] = 1'b0;
                ref_tag[idx]   = tg;
                ref_data[idx]  = ref_mem[word];
            end
            if (rw) begin
                ref_data[idx]  = merge_lanes(ref_data[idx], wdata, wen);
                ref_dirty[idx] = 1'b1;
            end
            exp = ref_data[idx];
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] addr,
                              input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s addr %h expected %h, got %h",
                     $time, name, addr, exp, got);
            errors++;
        end
    endtask

    // drive one request, hold until ready, check reads against the model
    task automatic access(input logic [31:0] addr, input logic rw, input logic [3:0] wen,
                          input logic [31:0] wdata, output logic [31:0] rdata);
        mem_pkg::bus_req_t req;
        logic [31:0]       exp;
        int                waited;
        rdata = '0;
        if (hung) begin
            return;
        end
        req.strobe = 1'b1;
        req.rw     = rw;
        req.wen    = rw ? wen : 4'b0000;
        req.size   = rw ? size_of(wen) : mem_pkg::SIZE_WORD;
        req.addr   = addr;
        req.wdata  = wdata;
        @(posedge clk);
        cpu_req <= req;
        @(negedge clk);
        waited = 0;
        while (!cpu_rsp.ready && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cpu_rsp.ready) begin
            $display("timeout: no cpu_rsp.ready within %0d cycles, addr %h", MAX_WAIT, addr);
            hung = 1'b1;
            return;
        end
        rdata = cpu_rsp.rdata;
        @(posedge clk);
        cpu_req.strobe <= 1'b0;
        model_step(addr, rw, wen, wdata, exp);
        if (!rw) begin
            check_word("cpu_rsp.rdata", addr, exp, rdata);
        end
    endtask

    task automatic begin_test();
        test_start_errs = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start_errs || hung) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_start_errs);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] got;
        logic [31:0] old_v;
        logic [3:0]  wen_list [6];
        clk          = 1'b0;
        rst          = 1'b1;
        cpu_req      = '0;
        rng          = 32'd67342;
        hung         = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        wen_set      = '{4'b1111, 4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000};
        wen_list     = '{4'b1000, 4'b0100, 4'b0011, 4'b0010, 4'b0001, 4'b1100};
        for (int i = 0; i < LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
        end

        begin_test();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            checks++;
            assert (!cpu_rsp.ready) else begin
                $display("cpu_rsp.ready went high after reset with no strobe at %0d ns", $time);
                errors++;
            end
        end
        end_test("reset idle");

        // fill the 2 KB window through the uncached alias
        for (int w = 0; w < 512; w++) begin
            draw(d);
            access(32'hA000_0000 + (w << 2), 1'b1, 4'b1111, d, got);
        end

        begin_test();
        access(32'h8000_0040, 1'b1, 4'b1111, 32'h1122_3344, got);
        access(32'h8000_0040, 1'b0, 4'b0000, '0, got);
        access(32'h8000_0040, 1'b1, 4'b0110, 32'hAABB_CCDD, got);
        access(32'h8000_0040, 1'b0, 4'b0000, '0, got);
        check_word("merged word", 32'h8000_0040, 32'h11BB_CC44, got);
        end_test("cached write and read");

        begin_test();
        access(32'h8000_0084, 1'b1, 4'b1111, 32'h0F0F_0F0F, got);
        for (int i = 0; i < 6; i++) begin
            draw(d);
            access(32'h8000_0084, 1'b1, wen_list[i], d, got);
            access(32'h8000_0084, 1'b0, 4'b0000, '0, got);
        end
        end_test("byte and halfword lanes");

        begin_test();
        access(32'h8000_0100, 1'b1, 4'b1111, 32'hDEAD_BEEF, got);
        access(32'h8000_0200, 1'b0, 4'b0000, '0, got);  // same index, evicts
        access(32'hA000_0100, 1'b0, 4'b0000, '0, got);
        check_word("written-back word", 32'hA000_0100, 32'hDEAD_BEEF, got);
        end_test("dirty eviction");

        begin_test();
        access(32'h8000_0310, 1'b0, 4'b0000, '0, old_v);
        access(32'h8000_0310, 1'b1, 4'b1111, ~old_v, got);
        access(32'hA000_0310, 1'b0, 4'b0000, '0, got);
        check_word("stale memory word", 32'hA000_0310, ref_mem[32'h310 >> 2], got);
        end_test("uncached read of dirty line");

        begin_test();
        access(32'h8000_0520, 1'b0, 4'b0000, '0, got);  // index of 0x420 now holds 0x520
        access(32'hA000_0420, 1'b1, 4'b1111, 32'h5555_AAAA, got);
        access(32'h8000_0420, 1'b0, 4'b0000, '0, got);
        check_word("non-resident alias", 32'h8000_0420, 32'h5555_AAAA, got);
        access(32'hA000_0420, 1'b1, 4'b1111, 32'h1234_5678, got);
        access(32'h8000_0420, 1'b0, 4'b0000, '0, got);
        check_word("resident alias", 32'h8000_0420, 32'h5555_AAAA, got);
        end_test("uncached write then cached read");

        begin_test();
        for (int n = 0; n < 2000 && !hung; n++) begin
            draw(r);
            draw(d);
            // segment 8..B, word offset inside 2 KB
            access({2'b10, r[1:0], 17'd0, r[10:2], 2'b00}, r[11], wen_set[r[14:12] % 7], d, got);
        end
        end_test("random mix");

        if (hung) begin
            $display("run stopped early, the DUT did not answer a request");
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !hung) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
mem_pkg.sv
addr_map.sv
d_cache.sv
mem_port_mux.sv
main_mem.sv
data_mem_top.sv
tb_data_mem.sv

// File: run.sh
#!/bin/sh
# build and run the data memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_data_mem -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
